// ==== files.f ====
hdl/rsbPkg.sv
hdl/slotDecoder.sv
hdl/groupQueue.sv
hdl/returnStack.sv
hdl/rsbTop.sv
tests/rsbTb.sv

// ==== tests/rsbTb.sv ====
// ============================================================
// testbench for the return stack predictor
// LFSR stimulus, reference stack model, prediction and top checks
// ============================================================
`timescale 1ns/100ps

module rsbTb import rsbPkg::*; ();

	// how the testbench builds a slot
	typedef enum int {
		formNone, formJalCall, formJalRet, formCall, formRet, formJalOther
	} slotForm;

	logic                 clk4x;
	logic                 rst;
	logic                 fetchValid;
	fetchGroup            fetchIn;
	logic                 fetchReady;
	logic                 predValid;
	retPrediction         predOut;
	logic                 predReady;
	logic [AddrWidth-1:0] topAddr;

	// separate LFSR states for the stimulus and the back-pressure process
	logic [15:0]          stimLfsr;
	logic [15:0]          readyLfsr;
	logic                 pressureOn;
	logic [SnWidth-1:0]   snNext;

	// reference model state
	logic [AddrWidth-1:0] mStack [StackDepth];
	logic [3:0]           mSp;
	logic [SnWidth-1:0]   mLastSn;
	logic                 mLastValid;
	retPrediction         expQ [$];

	rsbTop dut (
		.clk4x      (clk4x),
		.rst        (rst),
		.fetchValid (fetchValid),
		.fetchIn    (fetchIn),
		.fetchReady (fetchReady),
		.predValid  (predValid),
		.predOut    (predOut),
		.predReady  (predReady),
		.topAddr    (topAddr)
	);

	initial begin
		clk4x = 1'b0;
		forever #20 clk4x = ~clk4x;
	end

	// ============================================================
	// random bits, reference model and checks
	// ============================================================

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one LFSR step for every bit taken
	function automatic logic [31:0] stimBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stimLfsr = lfsrStep(stimLfsr);
			v = {v[30:0], stimLfsr[0]};
		end
		return v;
	endfunction

	function automatic logic readyBit();
		readyLfsr = lfsrStep(readyLfsr);
		return readyLfsr[0];
	endfunction

	// aligned bundle addresses high in the address space
	function automatic logic [AddrWidth-1:0] bundleIp(input int n);
		return 80'h0000_0000_0040_0000_0000 + (AddrWidth'(n) << 4);
	endfunction

	// applies one fetched group to the model stack at its handshake
	function automatic void rsbModel(input fetchGroup g);
		logic                 isCall;
		logic                 isRet;
		retPrediction         p;
		logic [AddrWidth-1:0] offset;
		// a refetch of the last acted-on group is ignored
		if (mLastValid && g.sn == mLastSn) begin
			return;
		end
		for (int k = 0; k < 3; k++) begin
			isCall = g.slot[k].queued && (g.slot[k].call ||
				(g.slot[k].jal && g.slot[k].Rd == LinkReg));
			isRet = g.slot[k].queued && !isCall && (g.slot[k].ret ||
				(g.slot[k].jal && g.slot[k].Ra == LinkReg));
			if (isCall || isRet) begin
				mLastSn = g.sn;
				mLastValid = 1'b1;
				if (isCall) begin
					// next slot sits at nibble 5, A or in the next bundle
					offset = (k == 0) ? 80'h5 : (k == 1) ? 80'hA : 80'h10;
					mSp = mSp - 4'd1;
					mStack[mSp] = g.ip + offset;
				end else begin
					p.sn = g.sn;
					p.target = mStack[mSp];
					expQ.push_back(p);
					mSp = mSp + 4'd1;
				end
				return;
			end
		end
	endfunction

	task automatic failWith(input string what);
		$display("%s at %0t", what, $time);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkPrediction(input retPrediction exp, input retPrediction act);
		if (act !== exp) begin
			$display("error at %0t: predOut expected sn %0d target %h, got sn %0d target %h",
				$time, exp.sn, exp.target, act.sn, act.target);
			$display(">>> FAIL");
			$fatal(1, "prediction mismatch");
		end
	endtask

	task automatic checkTop(input logic [AddrWidth-1:0] exp, input logic [AddrWidth-1:0] act);
		if (act !== exp) begin
			$display("error at %0t: topAddr expected %h, got %h", $time, exp, act);
			$display(">>> FAIL");
			$fatal(1, "top of stack mismatch");
		end
	endtask

	// drives predReady and compares every prediction handshake
	// both signals are steady while the clock is low
	initial begin : readyAndCheck
		retPrediction exp;
		readyLfsr = 16'd15658;
		pressureOn = 1'b0;
		predReady = 1'b1;
		forever begin
			@(negedge clk4x);
			// roughly one cycle in four drops ready under pressure
			predReady = pressureOn ? (readyBit() | readyBit()) : 1'b1;
			if (predValid && predReady) begin
				if (expQ.size() == 0) begin
					failWith("a prediction came out while none was expected");
				end
				exp = expQ.pop_front();
				checkPrediction(exp, predOut);
			end
		end
	end

	// ============================================================
	// stimulus tasks
	// ============================================================

	function automatic fetchSlot makeSlot(input slotForm f, input logic q,
		input logic [RegWidth-1:0] ra, input logic [RegWidth-1:0] rd);
		fetchSlot s;
		s = '0;
		s.queued = q;
		s.Ra = ra;
		s.Rd = rd;
		case (f)
			formJalCall: begin
				s.jal = 1'b1;
				s.Rd = LinkReg;
			end
			formJalRet: begin
				s.jal = 1'b1;
				s.Ra = LinkReg;
			end
			formCall: s.call = 1'b1;
			formRet: s.ret = 1'b1;
			formJalOther: s.jal = 1'b1;
			default: s.jal = 1'b0;
		endcase
		return s;
	endfunction

	// fetchReady has no path from fetchValid, so it is steady here
	task automatic sendGroup(input fetchGroup g);
		int cycles;
		fetchValid = 1'b1;
		fetchIn = g;
		cycles = 0;
		while (!fetchReady) begin
			@(negedge clk4x);
			cycles++;
			if (cycles > 100) begin
				failWith("fetch handshake hung, fetchReady stayed low");
			end
		end
		rsbModel(g);
		@(negedge clk4x);
	endtask

	task automatic sendForms(input logic [AddrWidth-1:0] ip, input slotForm f0,
		input slotForm f1, input slotForm f2, input logic [2:0] qMask, input logic reuseSn);
		fetchGroup g;
		g.ip = ip;
		g.sn = reuseSn ? snNext - 1'b1 : snNext;
		if (!reuseSn) begin
			snNext = snNext + 1'b1;
		end
		g.slot[0] = makeSlot(f0, qMask[0], 6'd3, 6'd9);
		g.slot[1] = makeSlot(f1, qMask[1], 6'd3, 6'd9);
		g.slot[2] = makeSlot(f2, qMask[2], 6'd3, 6'd9);
		sendGroup(g);
	endtask

	task automatic sendRandomGroup();
		fetchGroup   g;
		logic [31:0] r;
		slotForm     f;
		r = stimBits(16);
		g.ip = bundleIp(r[15:0]);
		// one group in eight repeats the previous sn
		g.sn = (stimBits(3) == 0) ? snNext - 1'b1 : snNext;
		if (g.sn == snNext) begin
			snNext = snNext + 1'b1;
		end
		for (int k = 0; k < 3; k++) begin
			r = stimBits(3);
			case (r[2:0])
				3'd1: f = formJalCall;
				3'd2: f = formJalRet;
				3'd3: f = formCall;
				3'd4: f = formRet;
				3'd5: f = formJalOther;
				default: f = formNone;
			endcase
			g.slot[k] = makeSlot(f, stimBits(2) != 0, RegWidth'(stimBits(6)),
				RegWidth'(stimBits(6)));
		end
		sendGroup(g);
		if (stimBits(2) == 0) begin
			fetchValid = 1'b0;
			repeat (1 + stimBits(2)) @(negedge clk4x);
		end
	endtask

	// idle means nothing in flight and qReady high for three cycles
	task automatic waitIdle();
		int quiet;
		int cycles;
		fetchValid = 1'b0;
		quiet = 0;
		cycles = 0;
		while (quiet < 3) begin
			@(negedge clk4x);
			cycles++;
			if (!dut.decValid && !dut.qValid && dut.qReady && !predValid &&
				expQ.size() == 0) begin
				quiet++;
			end else begin
				quiet = 0;
			end
			if (cycles > 400) begin
				failWith("stack engine never went idle, qReady or predValid stuck");
			end
		end
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial begin : stimulus
		rst = 1'b1;
		fetchValid = 1'b0;
		fetchIn = '0;
		stimLfsr = 16'd15658;
		snNext = '0;
		for (int i = 0; i < StackDepth; i++) begin
			mStack[i] = RstReturn;
		end
		mSp = '0;
		mLastSn = '0;
		mLastValid = 1'b0;
		repeat (3) @(posedge clk4x);
		@(negedge clk4x);
		rst = 1'b0;

		// quiet after reset, the top holds the reset vector
		for (int i = 0; i < 8; i++) begin
			@(negedge clk4x);
			if (predValid) begin
				failWith("predValid rose with no group fetched");
			end
		end
		waitIdle();
		checkTop(RstReturn, topAddr);

		// a call in each slot position, each popped by the next group
		for (int k = 0; k < 3; k++) begin
			sendForms(bundleIp(16'hFFFF - k), (k == 0) ? formCall : formNone,
				(k == 1) ? formCall : formNone, (k == 2) ? formCall : formNone, 3'b111, 1'b0);
			sendForms(bundleIp(k + 1), formRet, formNone, formNone, 3'b111, 1'b0);
		end
		waitIdle();
		checkTop(mStack[mSp], topAddr);

		// first flow-control slot wins, unqueued slots are skipped
		sendForms(bundleIp(32), formNone, formJalCall, formRet, 3'b111, 1'b0);
		sendForms(bundleIp(33), formRet, formJalRet, formCall, 3'b110, 1'b0);
		sendForms(bundleIp(34), formCall, formJalRet, formNone, 3'b111, 1'b0);
		sendForms(bundleIp(35), formJalOther, formCall, formRet, 3'b111, 1'b0);
		sendForms(bundleIp(36), formCall, formCall, formRet, 3'b000, 1'b0);
		sendForms(bundleIp(37), formNone, formNone, formRet, 3'b100, 1'b0);
		sendForms(bundleIp(38), formJalRet, formNone, formNone, 3'b111, 1'b0);
		waitIdle();
		checkTop(mStack[mSp], topAddr);

		// a refetch with the last acted-on sn leaves the stack alone
		sendForms(bundleIp(40), formCall, formNone, formNone, 3'b111, 1'b0);
		sendForms(bundleIp(41), formCall, formNone, formNone, 3'b111, 1'b1);
		sendForms(bundleIp(42), formRet, formNone, formNone, 3'b111, 1'b1);
		waitIdle();
		checkTop(mStack[mSp], topAddr);
		sendForms(bundleIp(43), formRet, formNone, formNone, 3'b111, 1'b0);
		waitIdle();
		checkTop(mStack[mSp], topAddr);

		// 20 nested calls wrap the stack, 22 returns run past the bottom
		for (int i = 0; i < 20; i++) begin
			sendForms(bundleIp(64 + i), formJalCall, formNone, formNone, 3'b111, 1'b0);
		end
		for (int i = 0; i < 22; i++) begin
			sendForms(bundleIp(96 + i), formNone, formRet, formNone, 3'b111, 1'b0);
		end
		waitIdle();
		checkTop(mStack[mSp], topAddr);

		// long random run with fetch gaps and predReady back-pressure
		@(posedge clk4x);
		pressureOn = 1'b1;
		@(negedge clk4x);
		for (int i = 0; i < 300; i++) begin
			sendRandomGroup();
		end
		waitIdle();
		checkTop(mStack[mSp], topAddr);

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== hdl/rsbTop.sv ====
// ============================================================
// return stack predictor top level
// decoder feeds the group queue, which feeds the stack engine
// ============================================================
`timescale 1ns/100ps

module rsbTop import rsbPkg::*; (
	input  logic                 clk4x,
	input  logic                 rst,

	// fetched bundles
	input  logic                 fetchValid,
	input  fetchGroup            fetchIn,
	output logic                 fetchReady,

	// return predictions
	output logic                 predValid,
	output retPrediction         predOut,
	input  logic                 predReady,

	// top of the return stack
	output logic [AddrWidth-1:0] topAddr
);

	// decoder to queue
	logic        decValid;
	logic        decReady;
	decodedGroup decOut;

	// queue to stack engine
	logic        qValid;
	logic        qReady;
	decodedGroup qData;

	slotDecoder uDec (
		.clk4x      (clk4x),
		.rst        (rst),
		.fetchValid (fetchValid),
		.fetchIn    (fetchIn),
		.fetchReady (fetchReady),
		.decValid   (decValid),
		.decReady   (decReady),
		.decOut     (decOut)
	);

	groupQueue #(
		.payloadT (decodedGroup)
	) uQueue (
		.clk4x    (clk4x),
		.rst      (rst),
		.inValid  (decValid),
		.inData   (decOut),
		.inReady  (decReady),
		.outValid (qValid),
		.outData  (qData),
		.outReady (qReady)
	);

	returnStack uStack (
		.clk4x     (clk4x),
		.rst       (rst),
		.qValid    (qValid),
		.qData     (qData),
		.qReady    (qReady),
		.predValid (predValid),
		.predOut   (predOut),
		.predReady (predReady),
		.topAddr   (topAddr)
	);

endmodule

// ==== hdl/returnStack.sv ====
// ============================================================
// return stack engine, scans one slot per cycle and pushes or
// pops a circular return address stack, emits return predictions
// ============================================================
`timescale 1ns/100ps

module returnStack import rsbPkg::*; (
	input  logic                 clk4x,
	input  logic                 rst,

	// decoded groups from the queue
	input  logic                 qValid,
	input  decodedGroup          qData,
	output logic                 qReady,

	// predicted return targets
	output logic                 predValid,
	output retPrediction         predOut,
	input  logic                 predReady,

	// current top of stack, a plain level
	output logic [AddrWidth-1:0] topAddr
);

	// ============================================================
	// state
	// ============================================================

	logic [AddrWidth-1:0]     stack [StackDepth];
	// pointer names the top entry, pushes go one below it
	logic [StackPtrWidth-1:0] sp;

	// group under scan and the slot examined at the next edge
	decodedGroup              grp;
	logic                     busy;
	logic [1:0]               phase;
	// set once a slot of the current group has acted
	logic                     groupDone;

	// sequence number of the last group that changed the stack
	logic [SnWidth-1:0]       lastSn;
	logic                     lastSnValid;

	logic                     stall;
	logic                     replay;
	slotKind                  curKind;
	logic                     slotActs;

	// ============================================================
	// slot evaluation
	// ============================================================

	// an unread prediction freezes the engine where it stands
	assign stall  = predValid && !predReady;
	assign qReady = !busy && !stall;

	// a refetched bundle carries the sn of the last group acted on
	assign replay  = lastSnValid && (grp.sn == lastSn);
	assign curKind = grp.kind[phase];

	// only the first flow-control slot of a fresh group touches the stack
	assign slotActs = busy && !stall && !groupDone && !replay &&
		(curKind != slotNone);

	assign topAddr = stack[sp];

	// ============================================================
	// scan sequencer and stack update
	// ============================================================

	always_ff @(posedge clk4x) begin
		if (rst) begin
			busy        <= 1'b0;
			phase       <= 2'd0;
			groupDone   <= 1'b0;
			sp          <= '0;
			lastSnValid <= 1'b0;
			predValid   <= 1'b0;
			for (int i = 0; i < StackDepth; i++) begin
				stack[i] <= RstReturn;
			end
		end else begin
			// a taken prediction drops unless a new pop replaces it below
			if (predValid && predReady) begin
				predValid <= 1'b0;
			end

			if (qValid && qReady) begin
				// start a scan at slot 0 on the next edge
				grp       <= qData;
				busy      <= 1'b1;
				phase     <= 2'd0;
				groupDone <= 1'b0;
			end else if (busy && !stall) begin
				if (slotActs) begin
					groupDone   <= 1'b1;
					lastSn      <= grp.sn;
					lastSnValid <= 1'b1;
					if (curKind == slotCall) begin
						// overflow quietly overwrites the oldest entry
						stack[sp - 1'b1] <= nextSlotAddr(grp.ip, phase);
						sp               <= sp - 1'b1;
					end else begin
						predOut.sn     <= grp.sn;
						predOut.target <= stack[sp];
						predValid      <= 1'b1;
						sp             <= sp + 1'b1;
					end
				end

				// slot 2 ends the group, the engine goes idle
				if (phase == 2'd2) begin
					busy  <= 1'b0;
					phase <= 2'd0;
				end else begin
					phase <= phase + 1'b1;
				end
			end
		end
	end

	// ============================================================
	// checks
	// ============================================================

	// three slots per bundle, so the counter never reaches 3
	aPhaseRange: assert property (@(posedge clk4x) disable iff (rst)
		phase <= 2'd2)
		else $error("slot phase counter out of range");

	// a held prediction keeps its sn and target until it is taken
	aPredStable: assert property (@(posedge clk4x) disable iff (rst)
		predValid && !predReady |=> predValid && $stable(predOut))
		else $error("prediction changed under back-pressure");

endmodule

// ==== hdl/groupQueue.sv ====
// ============================================================
// synchronous circular FIFO with a type parameter for its payload
// buffers decoded groups between decoder and stack engine
// ============================================================
`timescale 1ns/100ps

module groupQueue import rsbPkg::*; #(
	parameter type payloadT = decodedGroup
) (
	input  logic    clk4x,
	input  logic    rst,

	// write side
	input  logic    inValid,
	input  payloadT inData,
	output logic    inReady,

	// read side
	output logic    outValid,
	output payloadT outData,
	input  logic    outReady
);

	// storage has no reset, only pointers and count do
	payloadT mem [QueueDepth];

	logic [QueuePtrWidth-1:0] wrPtr;
	logic [QueuePtrWidth-1:0] rdPtr;
	logic [QueueCntWidth-1:0] count;
	logic                     wrEn;
	logic                     rdEn;

	// step a pointer, wrapping at the last entry
	function automatic logic [QueuePtrWidth-1:0] stepPtr(
		input logic [QueuePtrWidth-1:0] p
	);
		if (p == QueuePtrWidth'(QueueDepth - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// full blocks writes even when a read happens on the same edge
	assign inReady  = (count != QueueCntWidth'(QueueDepth));
	assign outValid = (count != '0);
	assign outData  = mem[rdPtr];

	assign wrEn = inValid && inReady;
	assign rdEn = outValid && outReady;

	always_ff @(posedge clk4x) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (wrEn) begin
				wrPtr <= stepPtr(wrPtr);
			end
			if (rdEn) begin
				rdPtr <= stepPtr(rdPtr);
			end
			// count only changes when exactly one side moves
			if (wrEn && !rdEn) begin
				count <= count + 1'b1;
			end else if (rdEn && !wrEn) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk4x) begin
		if (wrEn) begin
			mem[wrPtr] <= inData;
		end
	end

	// ============================================================
	// checks
	// ============================================================

	// occupancy never runs past the array so a full queue took no write
	aNoOverflow: assert property (@(posedge clk4x) disable iff (rst)
		count <= QueueCntWidth'(QueueDepth))
		else $error("group queue written while full");

	// an empty queue has its read pointer back on the write pointer
	aNoUnderflow: assert property (@(posedge clk4x) disable iff (rst)
		count == '0 |-> rdPtr == wrPtr)
		else $error("group queue read while empty");

endmodule

// ==== hdl/slotDecoder.sv ====
// ============================================================
// slot decoder, classifies the three slots of a fetched bundle
// as call, return or neither and registers the decoded group
// ============================================================
`timescale 1ns/100ps

module slotDecoder import rsbPkg::*; (
	input  logic        clk4x,
	input  logic        rst,

	// fetched bundles from the front end
	input  logic        fetchValid,
	input  fetchGroup   fetchIn,
	output logic        fetchReady,

	// decoded bundles toward the group queue
	output logic        decValid,
	input  logic        decReady,
	output decodedGroup decOut
);

	// ============================================================
	// classification
	// ============================================================

	// a call is an explicit call or a jal writing the link register
	// a return is an explicit ret or a jal reading the link register
	// call wins when a jal names the link register on both sides
	function automatic slotKind classifySlot(input fetchSlot s);
		slotKind k;
		k = slotNone;
		if (s.queued) begin
			if (s.call || (s.jal && s.Rd == LinkReg)) begin
				k = slotCall;
			end else if (s.ret || (s.jal && s.Ra == LinkReg)) begin
				k = slotRet;
			end
		end
		return k;
	endfunction

	decodedGroup decNext;
	logic        takeIn;

	// build the decoded form of the incoming bundle
	always_comb begin
		decNext.ip = fetchIn.ip;
		decNext.sn = fetchIn.sn;
		for (int k = 0; k < 3; k++) begin
			decNext.kind[k] = classifySlot(fetchIn.slot[k]);
		end
	end

	// ============================================================
	// output register stage
	// ============================================================

	// the stage can take a new bundle when it is empty or is being
	// drained on this same edge, which keeps one group per cycle
	assign fetchReady = !decValid || decReady;
	assign takeIn = fetchValid && fetchReady;

	// valid bit carries the control state
	always_ff @(posedge clk4x) begin
		if (rst) begin
			decValid <= 1'b0;
		end else if (takeIn) begin
			decValid <= 1'b1;
		end else if (decReady) begin
			decValid <= 1'b0;
		end
	end

	// payload only moves when a new bundle is accepted
	always_ff @(posedge clk4x) begin
		if (takeIn) begin
			decOut <= decNext;
		end
	end

	// ============================================================
	// checks
	// ============================================================

	// a stalled output must hold both its valid and its contents
	// until the queue takes it
	property pHoldWhileStalled;
		@(posedge clk4x) disable iff (rst)
		decValid && !decReady |=> decValid && $stable(decOut);
	endproperty
	aHoldWhileStalled: assert property (pHoldWhileStalled)
		else $error("decoded group changed while the queue was full");

endmodule

// ==== hdl/rsbPkg.sv ====
// ============================================================
// shared widths, constants and reset vector for the return stack
// fetch slot, fetch group, decoded group and prediction structs
// slot classification enum and the next-slot address function
// ============================================================
package rsbPkg;

	// ============================================================
	// widths and sizes
	// ============================================================

	// instruction addresses are 80 bits, bundles are 16-byte aligned
	localparam int AddrWidth = 80;
	// fetch sequence number carried with every bundle
	localparam int SnWidth = 5;
	// register specifier width in a slot
	localparam int RegWidth = 6;

	// r61 is the link register used by jal-style calls and returns
	localparam logic [RegWidth-1:0] LinkReg = 6'd61;

	// return stack entries, must be a power of two for pointer wrap
	localparam int StackDepth = 16;
	localparam int StackPtrWidth = $clog2(StackDepth);

	// group queue entries between decoder and stack engine
	localparam int QueueDepth = 4;
	localparam int QueuePtrWidth = $clog2(QueueDepth);
	// count must be able to hold QueueDepth itself
	localparam int QueueCntWidth = $clog2(QueueDepth + 1);

	// every stack entry holds the reset vector after reset
	localparam logic [AddrWidth-1:0] RstReturn = 80'hFFFFFFFFFFFFFFFC0100;

	// ============================================================
	// types
	// ============================================================

	// what a slot does to the return stack
	typedef enum logic [1:0] {
		slotNone = 2'd0,
		slotCall = 2'd1,
		slotRet  = 2'd2
	} slotKind;

	// raw per-slot decode information supplied by the front end
	typedef struct packed {
		logic                queued;
		logic                jal;
		logic                call;
		logic                ret;
		logic [RegWidth-1:0] Ra;
		logic [RegWidth-1:0] Rd;
	} fetchSlot;

	// one fetched bundle, slot 0 sits in the low bits of the array
	typedef struct packed {
		logic [AddrWidth-1:0] ip;
		logic [SnWidth-1:0]   sn;
		fetchSlot [2:0]       slot;
	} fetchGroup;

	// bundle after classification, only the kind of each slot remains
	typedef struct packed {
		logic [AddrWidth-1:0] ip;
		logic [SnWidth-1:0]   sn;
		slotKind [2:0]        kind;
	} decodedGroup;

	// predicted target of a return, tagged with its fetch sequence number
	typedef struct packed {
		logic [SnWidth-1:0]   sn;
		logic [AddrWidth-1:0] target;
	} retPrediction;

	// address of the slot following slot slotIdx of the bundle at base
	// slots sit at nibble 0, 5 and A so slot 2 rolls into the next bundle
	function automatic logic [AddrWidth-1:0] nextSlotAddr(
		input logic [AddrWidth-1:0] base,
		input logic [1:0]           slotIdx
	);
		logic [AddrWidth-1:0] addr;
		case (slotIdx)
			2'd0: addr = {base[AddrWidth-1:4], 4'h5};
			2'd1: addr = {base[AddrWidth-1:4], 4'hA};
			default: addr = {base[AddrWidth-1:4] + 1'b1, 4'h0};
		endcase
		return addr;
	endfunction

endpackage
